//--- common/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// ------------------------------------------------------------
// core and memory sizing
// ------------------------------------------------------------

// data and byte address width
`define RV_XLEN 32

// unified memory depth in 32-bit words
`define RV_MEM_WORDS 1024

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

//--- common/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_XLEN-1:0] addr_t;  // byte address
  typedef logic [31:0]         instr_t;
  typedef logic [4:0]          reg_idx_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_LUI    = 7'b0110111,
    OPC_SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT
  } alu_op_t;

  typedef enum logic [1:0] {SRC_A_PC, SRC_A_OLD_PC, SRC_A_RS1} alu_src_a_t;
  typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR} alu_src_b_t;

  typedef enum logic [1:0] {RES_ALU_OUT, RES_MEM_DATA, RES_ALU_RESULT} result_src_t;

  typedef enum logic {ADR_PC, ADR_RESULT} adr_src_t;
  typedef enum logic {PC_SRC_RESULT, PC_SRC_ALU_OUT} pc_src_t;

  // multicycle sequencer states
  typedef enum logic [3:0] {
    ST_FETCH, ST_DECODE, ST_EXECUTE_R, ST_EXECUTE_I,
    ST_MEM_ADR, ST_MEM_READ, ST_MEM_WB, ST_MEM_WRITE,
    ST_ALU_WB, ST_BRANCH, ST_JAL, ST_LUI, ST_HALT
  } cpu_state_t;

endpackage

//--- common/mem_bus_if.sv
`timescale 1ns/1ps

// one requester's port on the shared memory bus
interface mem_bus_if
  import rv_pkg::*;
();

  logic  req;    // level, held until granted
  logic  we;
  addr_t addr;
  word_t wdata;
  word_t rdata;  // valid in the granted cycle
  logic  gnt;

  modport requester (output req, we, addr, wdata, input rdata, gnt);
  modport arbiter   (input req, we, addr, wdata, output rdata, gnt);

endinterface

//--- control/control_fsm.sv
`timescale 1ns/1ps

module control_fsm
  import rv_pkg::*;
(
  input  logic                clk,
  input  logic                arst_n,
  input  opcode_t             opcode,
  input  logic [2:0]          funct3,
  input  logic                zero,
  mem_bus_if.requester        data_bus,
  input  logic                fetch_gnt,
  output logic                ir_write,
  output logic                pc_update,
  output logic                reg_write,
  output pc_src_t             pc_src,
  output alu_src_a_t          alu_src_a,
  output alu_src_b_t          alu_src_b,
  output result_src_t         result_src,
  output logic                fetch_req,
  output logic                halted
);

  cpu_state_t state, state_next;
  logic       run_q;  // low for the first cycle out of reset
  logic       data_req, data_we, taken;

  assign taken = funct3[0] ? !zero : zero;  // bne : beq

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_FETCH;
      run_q <= 1'b0;
    end else begin
      state <= state_next;
      run_q <= 1'b1;
    end
  end

  // ------------------------------------------------------------
  // next state
  // ------------------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      ST_FETCH: if (run_q && fetch_gnt) state_next = ST_DECODE;
      ST_DECODE: begin
        case (opcode)
          OPC_OP: begin
            case (funct3)
              3'b000, 3'b010, 3'b100, 3'b110, 3'b111: state_next = ST_EXECUTE_R;
              default: state_next = ST_HALT;  // shifts, sltu
            endcase
          end
          OPC_OP_IMM: state_next = (funct3 == 3'b000) ? ST_EXECUTE_I : ST_HALT;
          OPC_LOAD, OPC_STORE: state_next = (funct3 == 3'b010) ? ST_MEM_ADR : ST_HALT;
          OPC_BRANCH: state_next = (funct3[2:1] == 2'b00) ? ST_BRANCH : ST_HALT;
          OPC_JAL:    state_next = ST_JAL;
          OPC_LUI:    state_next = ST_LUI;
          default:    state_next = ST_HALT;  // ecall and anything unknown
        endcase
      end
      ST_EXECUTE_R, ST_EXECUTE_I, ST_JAL, ST_LUI: state_next = ST_ALU_WB;
      ST_MEM_ADR:   state_next = (opcode == OPC_LOAD) ? ST_MEM_READ : ST_MEM_WRITE;
      ST_MEM_READ:  if (data_bus.gnt) state_next = ST_MEM_WB;
      ST_MEM_WRITE: if (data_bus.gnt) state_next = ST_FETCH;
      ST_MEM_WB, ST_ALU_WB, ST_BRANCH: state_next = ST_FETCH;
      default:      state_next = ST_HALT;
    endcase
  end

  // ------------------------------------------------------------
  // datapath controls
  // ------------------------------------------------------------
  always_comb begin
    ir_write   = 1'b0;
    pc_update  = 1'b0;
    reg_write  = 1'b0;
    fetch_req  = 1'b0;
    data_req   = 1'b0;
    data_we    = 1'b0;
    pc_src     = PC_SRC_RESULT;
    alu_src_a  = SRC_A_RS1;
    alu_src_b  = SRC_B_IMM;
    result_src = RES_ALU_OUT;
    case (state)
      ST_FETCH: begin
        fetch_req  = run_q;
        ir_write   = run_q && fetch_gnt;
        pc_update  = run_q && fetch_gnt;  // pc + 4
        alu_src_a  = SRC_A_PC;
        alu_src_b  = SRC_B_FOUR;
        result_src = RES_ALU_RESULT;
      end
      ST_DECODE:    alu_src_a = SRC_A_OLD_PC;  // branch / jump target
      ST_EXECUTE_R: alu_src_b = SRC_B_RS2;
      ST_MEM_READ:  data_req = 1'b1;  // alu_out keeps the address
      ST_MEM_WRITE: begin
        data_req = 1'b1;
        data_we  = 1'b1;
      end
      ST_MEM_WB: begin
        reg_write  = 1'b1;
        result_src = RES_MEM_DATA;
      end
      ST_ALU_WB: reg_write = 1'b1;
      ST_BRANCH: begin
        alu_src_b = SRC_B_RS2;
        pc_src    = PC_SRC_ALU_OUT;
        pc_update = taken;
      end
      ST_JAL: begin
        alu_src_a = SRC_A_OLD_PC;  // link value
        alu_src_b = SRC_B_FOUR;
        pc_src    = PC_SRC_ALU_OUT;
        pc_update = 1'b1;
      end
      default: ;
    endcase
  end

  assign data_bus.req = data_req;
  assign data_bus.we  = data_we;
  assign halted       = (state == ST_HALT);

endmodule

//--- src/fetch_unit.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module fetch_unit
  import rv_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  mem_bus_if.requester fetch_bus,
  input  logic         fetch_req,
  input  logic         ir_write,
  input  logic         pc_update,
  input  pc_src_t      pc_src,
  input  word_t        result,
  input  word_t        alu_out,
  output addr_t        pc,
  output addr_t        pc_old,
  output instr_t       instr
);

  addr_t pc_next;

  assign pc_next = (pc_src == PC_SRC_ALU_OUT) ? alu_out : result;

  // read-only requester
  assign fetch_bus.req   = fetch_req;
  assign fetch_bus.we    = 1'b0;
  assign fetch_bus.addr  = pc;
  assign fetch_bus.wdata = '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) pc <= `RV_RESET_PC;
    else if (pc_update) pc <= pc_next;
  end

  always_ff @(posedge clk) begin
    if (ir_write && fetch_bus.gnt) begin
      instr  <= fetch_bus.rdata;
      pc_old <= pc;  // address of this instruction
    end
  end

endmodule

//--- src/decode_regfile.sv
`timescale 1ns/1ps

module decode_regfile
  import rv_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  instr_t     instr,
  input  logic       reg_write,
  input  word_t      result,
  output opcode_t    opcode,
  output logic [2:0] funct3,
  output alu_op_t    alu_op,
  output word_t      imm,
  output word_t      rs1_q,
  output word_t      rs2_q
);

  word_t    regs [32];
  reg_idx_t rs1_idx, rs2_idx, rd_idx;
  word_t    rs1_d, rs2_d;

  assign opcode  = opcode_t'(instr[6:0]);
  assign funct3  = instr[14:12];
  assign rs1_idx = (opcode == OPC_LUI) ? '0 : instr[19:15];  // lui adds to x0
  assign rs2_idx = instr[24:20];
  assign rd_idx  = instr[11:7];

  // ------------------------------------------------------------
  // immediates
  // ------------------------------------------------------------
  always_comb begin
    case (opcode)
      OPC_OP_IMM, OPC_LOAD: imm = {{20{instr[31]}}, instr[31:20]};
      OPC_STORE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      OPC_BRANCH: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                         instr[11:8], 1'b0};
      OPC_JAL:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                         instr[30:21], 1'b0};
      OPC_LUI:    imm = {instr[31:12], 12'h000};
      default:    imm = '0;
    endcase
  end

  // alu operation from opcode and funct fields
  always_comb begin
    alu_op = ALU_ADD;  // loads, stores, jal, lui
    case (opcode)
      OPC_OP, OPC_OP_IMM: begin
        case (funct3)
          3'b000:  alu_op = (opcode == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
          3'b010:  alu_op = ALU_SLT;
          3'b100:  alu_op = ALU_XOR;
          3'b110:  alu_op = ALU_OR;
          3'b111:  alu_op = ALU_AND;
          default: alu_op = ALU_ADD;
        endcase
      end
      OPC_BRANCH: alu_op = ALU_SUB;  // compare via zero flag
      default: ;
    endcase
  end

  // ------------------------------------------------------------
  // register file, x0 reads as zero
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reg_write && rd_idx != '0) regs[rd_idx] <= result;
  end

  assign rs1_d = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_d = (rs2_idx == '0) ? '0 : regs[rs2_idx];

  // operand registers, stable while the instruction executes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rs1_q <= '0;
      rs2_q <= '0;
    end else begin
      rs1_q <= rs1_d;
      rs2_q <= rs2_d;
    end
  end

endmodule

//--- src/alu.sv
`timescale 1ns/1ps

module alu
  import rv_pkg::*;
(
  input  logic        clk,
  input  addr_t       pc,
  input  addr_t       pc_old,
  input  word_t       rs1_q,
  input  word_t       rs2_q,
  input  word_t       imm,
  input  word_t       mem_rdata,
  input  alu_op_t     alu_op,
  input  alu_src_a_t  alu_src_a,
  input  alu_src_b_t  alu_src_b,
  input  result_src_t result_src,
  output logic        zero,
  output word_t       alu_out,
  output word_t       result
);

  word_t   src_a, src_b, alu_result, data_q;
  alu_op_t op_eff;

  always_comb begin
    case (alu_src_a)
      SRC_A_PC:     src_a = pc;
      SRC_A_OLD_PC: src_a = pc_old;
      default:      src_a = rs1_q;
    endcase
    case (alu_src_b)
      SRC_B_RS2: src_b = rs2_q;
      SRC_B_IMM: src_b = imm;
      default:   src_b = word_t'(4);
    endcase
  end

  // pc arithmetic always adds, whatever the decoded op
  assign op_eff = (alu_src_a == SRC_A_RS1) ? alu_op : ALU_ADD;

  always_comb begin
    case (op_eff)
      ALU_SUB: alu_result = src_a - src_b;
      ALU_AND: alu_result = src_a & src_b;
      ALU_OR:  alu_result = src_a | src_b;
      ALU_XOR: alu_result = src_a ^ src_b;
      ALU_SLT: alu_result = word_t'($signed(src_a) < $signed(src_b));
      default: alu_result = src_a + src_b;
    endcase
  end

  assign zero = (alu_result == '0);

  always_ff @(posedge clk) begin
    alu_out <= alu_result;
    data_q  <= mem_rdata;  // load data for the write-back cycle
  end

  always_comb begin
    case (result_src)
      RES_MEM_DATA:   result = data_q;
      RES_ALU_RESULT: result = alu_result;
      default:        result = alu_out;
    endcase
  end

endmodule

//--- src/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
  import rv_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  mem_bus_if.arbiter load_bus,
  mem_bus_if.arbiter data_bus,
  mem_bus_if.arbiter fetch_bus,
  output logic       mem_we,
  output addr_t      mem_addr,
  output word_t      mem_wdata,
  input  word_t      mem_rdata,
  output logic       core_write
);

  logic [2:0]  grant;           // fetch, data, load

  // load beats data and data beats fetch
  assign grant[0] = load_bus.req;
  assign grant[1] = data_bus.req && !load_bus.req;
  assign grant[2] = fetch_bus.req && !load_bus.req && !data_bus.req;

  assign load_bus.gnt  = grant[0];
  assign data_bus.gnt  = grant[1];
  assign fetch_bus.gnt = grant[2];

  assign load_bus.rdata  = mem_rdata;
  assign data_bus.rdata  = mem_rdata;
  assign fetch_bus.rdata = mem_rdata;

  always_comb begin
    mem_we    = 1'b0;
    mem_addr  = fetch_bus.addr;
    mem_wdata = fetch_bus.wdata;
    if (grant[0]) begin
      mem_we    = load_bus.we;
      mem_addr  = load_bus.addr;
      mem_wdata = load_bus.wdata;
    end else if (grant[1]) begin
      mem_we    = data_bus.we;
      mem_addr  = data_bus.addr;
      mem_wdata = data_bus.wdata;
    end else if (grant[2]) begin
      mem_we    = fetch_bus.we;
    end
  end

  assign core_write = grant[1] && data_bus.we;

endmodule

//--- src/unified_memory.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module unified_memory
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  we,
  input  addr_t addr,
  input  word_t wdata,
  output word_t rdata
);

  localparam int IDX_W = $clog2(`RV_MEM_WORDS);

  word_t            mem [`RV_MEM_WORDS];
  logic [IDX_W-1:0] word_idx;

  // byte address to word index, upper bits wrap
  assign word_idx = addr[IDX_W+1:2];

  // combinational read
  assign rdata = mem[word_idx];

  always_ff @(posedge clk) begin
    if (we) mem[word_idx] <= wdata;
  end

endmodule

//--- src/mc_core.sv
`timescale 1ns/1ps

module mc_core
  import rv_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  load_en,
  input  addr_t load_addr,
  input  word_t load_data,
  output logic  mem_wr_valid,
  output addr_t mem_wr_addr,
  output word_t mem_wr_data,
  output logic  halted
);

  mem_bus_if load_bus ();
  mem_bus_if data_bus ();
  mem_bus_if fetch_bus ();

  logic        ir_write, pc_update, reg_write, fetch_req, zero;
  pc_src_t     pc_src;
  alu_src_a_t  alu_src_a;
  alu_src_b_t  alu_src_b;
  result_src_t result_src;
  opcode_t     opcode;
  logic [2:0]  funct3;
  alu_op_t     alu_op;
  addr_t       pc, pc_old;
  instr_t      instr;
  word_t       imm, rs1_q, rs2_q, alu_out, result;
  logic        mem_we, core_write;
  addr_t       mem_addr;
  word_t       mem_wdata, mem_rdata;

  // program-load port, write only
  assign load_bus.req   = load_en;
  assign load_bus.we    = load_en;
  assign load_bus.addr  = load_addr;
  assign load_bus.wdata = load_data;

  // data side address and store data
  assign data_bus.addr  = result;
  assign data_bus.wdata = rs2_q;

  control_fsm u_control_fsm (
    .clk(clk), .arst_n(arst_n), .opcode(opcode), .funct3(funct3), .zero(zero),
    .data_bus(data_bus), .fetch_gnt(fetch_bus.gnt), .ir_write(ir_write),
    .pc_update(pc_update), .reg_write(reg_write), .pc_src(pc_src),
    .alu_src_a(alu_src_a), .alu_src_b(alu_src_b), .result_src(result_src),
    .fetch_req(fetch_req), .halted(halted)
  );

  fetch_unit u_fetch_unit (
    .clk(clk), .arst_n(arst_n), .fetch_bus(fetch_bus), .fetch_req(fetch_req),
    .ir_write(ir_write), .pc_update(pc_update), .pc_src(pc_src), .result(result),
    .alu_out(alu_out), .pc(pc), .pc_old(pc_old), .instr(instr)
  );

  decode_regfile u_decode_regfile (
    .clk(clk), .arst_n(arst_n), .instr(instr), .reg_write(reg_write),
    .result(result), .opcode(opcode), .funct3(funct3), .alu_op(alu_op),
    .imm(imm), .rs1_q(rs1_q), .rs2_q(rs2_q)
  );

  alu u_alu (
    .clk(clk), .pc(pc), .pc_old(pc_old), .rs1_q(rs1_q), .rs2_q(rs2_q), .imm(imm),
    .mem_rdata(data_bus.rdata), .alu_op(alu_op), .alu_src_a(alu_src_a),
    .alu_src_b(alu_src_b), .result_src(result_src), .zero(zero),
    .alu_out(alu_out), .result(result)
  );

  mem_arbiter u_mem_arbiter (
    .clk(clk), .arst_n(arst_n), .load_bus(load_bus), .data_bus(data_bus),
    .fetch_bus(fetch_bus), .mem_we(mem_we), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .core_write(core_write)
  );

  unified_memory u_unified_memory (
    .clk(clk), .we(mem_we), .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
  );

  // store trace, core data writes only
  assign mem_wr_valid = core_write;
  assign mem_wr_addr  = mem_addr;
  assign mem_wr_data  = mem_wdata;

endmodule

//--- verification/tb_ref_pkg.sv
package tb_ref_pkg;

  import rv_pkg::*;

  // major opcodes as the isa encodes them
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_LUI    = 7'b0110111;

  localparam int MODEL_WORDS = 1024;
  localparam int STEP_LIMIT  = 4000;  // stops a runaway program

  // expected store trace, in program order
  word_t exp_addr[$];
  word_t exp_data[$];

  // runs the image from address 0 and returns the number of instructions
  // executed, the one that stops the core included
  function automatic int run_reference(input instr_t image[$]);
    word_t      mem [MODEL_WORDS];
    word_t      x [32];
    addr_t      pc, next_pc, ea;
    instr_t     ins;
    word_t      a, b, wr_val, imm_i, imm_s, imm_b, imm_j;
    logic [2:0] f3;
    bit         wr_en, stop;
    int         count;
    exp_addr.delete();
    exp_data.delete();
    foreach (mem[i]) mem[i] = '0;
    foreach (x[i]) x[i] = '0;
    foreach (image[i]) mem[i] = image[i];
    pc    = '0;
    stop  = 1'b0;
    count = 0;
    while (!stop && count < STEP_LIMIT) begin
      ins = mem[pc[11:2]];
      count++;
      a       = x[ins[19:15]];
      b       = x[ins[24:20]];
      f3      = ins[14:12];
      imm_i   = {{20{ins[31]}}, ins[31:20]};
      imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      next_pc = pc + 4;
      wr_en   = 1'b0;
      wr_val  = '0;
      case (ins[6:0])
        OP_REG: begin
          wr_en = 1'b1;
          case (f3)
            3'b000:  wr_val = ins[30] ? a - b : a + b;
            3'b010:  wr_val = word_t'($signed(a) < $signed(b));
            3'b100:  wr_val = a ^ b;
            3'b110:  wr_val = a | b;
            3'b111:  wr_val = a & b;
            default: stop = 1'b1;  // shifts and sltu are outside the subset
          endcase
        end
        OP_IMM: begin
          wr_en  = 1'b1;
          wr_val = a + imm_i;
          stop   = (f3 != 3'b000);  // addi only
        end
        OP_LOAD: begin
          ea     = a + imm_i;
          wr_en  = 1'b1;
          wr_val = mem[ea[11:2]];
          stop   = (f3 != 3'b010);
        end
        OP_STORE: begin
          ea   = a + imm_s;
          stop = (f3 != 3'b010);
          if (!stop) begin
            exp_addr.push_back(ea);
            exp_data.push_back(b);
            mem[ea[11:2]] = b;
          end
        end
        OP_BRANCH: begin
          stop = (f3[2:1] != 2'b00);  // beq and bne
          if ((f3[0] == 1'b0) == (a == b)) next_pc = pc + imm_b;
        end
        OP_JAL: begin
          wr_en   = 1'b1;
          wr_val  = pc + 4;
          next_pc = pc + imm_j;
        end
        OP_LUI: begin
          wr_en  = 1'b1;
          wr_val = {ins[31:12], 12'h000};
        end
        default: stop = 1'b1;  // ecall and undefined opcodes
      endcase
      if (wr_en && !stop && ins[11:7] != 5'd0) x[ins[11:7]] = wr_val;
      if (!stop) pc = next_pc;
    end
    return count;
  endfunction

endpackage

//--- verification/tb_mc_core.sv
`timescale 1ns/1ps

module tb_mc_core
  import rv_pkg::*;
  import tb_ref_pkg::*;
();

  localparam int     TIMEOUT_CYCLES = 5000;
  localparam int     DRAIN_CYCLES   = 20;
  localparam int     DATA_BASE      = 'h400;       // word 256, above every program
  localparam addr_t  FREE_BASE      = 32'h0000_0c00;  // load pulses land here
  localparam [31:0]  SEED           = 32'hf7f1efb9;
  localparam instr_t ECALL          = 32'h0000_0073;
  localparam instr_t ILLEGAL_OP     = 32'h0000_000b;

  logic  clk       = 1'b0;
  logic  arst_n    = 1'b0;
  logic  load_en   = 1'b0;
  addr_t load_addr = '0;
  word_t load_data = '0;
  logic  mem_wr_valid, halted;
  addr_t mem_wr_addr;
  word_t mem_wr_data;

  instr_t prog[$];
  string  test_name = "none";
  int     exp_count;
  int     store_idx    = 0;
  int     instr_seen   = 0;
  int     store_errors = 0;  // comparison process only
  int     run_errors   = 0;  // stimulus process only
  bit     store_ok;

  mc_core dut (
    .clk(clk), .arst_n(arst_n), .load_en(load_en), .load_addr(load_addr),
    .load_data(load_data), .mem_wr_valid(mem_wr_valid), .mem_wr_addr(mem_wr_addr),
    .mem_wr_data(mem_wr_data), .halted(halted)
  );

  always #50 clk = ~clk;

  // ------------------------------------------------------------
  // instruction encoders
  // ------------------------------------------------------------
  function automatic instr_t r_type(logic [2:0] f3, logic [6:0] f7, int rd, int rs1, int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_REG};
  endfunction

  function automatic instr_t i_type(logic [6:0] opc, logic [2:0] f3, int rd, int rs1, int imm);
    return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
  endfunction

  function automatic instr_t addi(int rd, int rs1, int imm);
    return i_type(OP_IMM, 3'b000, rd, rs1, imm);
  endfunction

  function automatic instr_t s_type(int rs2, int rs1, int imm);  // sw
    logic [11:0] v;
    v = 12'(imm);
    return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], OP_STORE};
  endfunction

  function automatic instr_t b_type(logic [2:0] f3, int rs1, int rs2, int imm);
    logic [12:0] v;
    v = 13'(imm);
    return {v[12], v[10:5], 5'(rs2), 5'(rs1), f3, v[4:1], v[11], OP_BRANCH};
  endfunction

  function automatic instr_t j_type(int rd, int imm);
    logic [20:0] v;
    v = 21'(imm);
    return {v[20], v[10:1], v[11], v[19:12], 5'(rd), OP_JAL};
  endfunction

  function automatic instr_t u_type(int rd, logic [19:0] upper);
    return {upper, 5'(rd), OP_LUI};
  endfunction

  function automatic int rand_reg();
    return 1 + int'($urandom % 15);  // x1..x15, x20 stays the base
  endfunction

  function automatic int rand_imm();
    return int'($urandom % 4096) - 2048;
  endfunction

  // ------------------------------------------------------------
  // program images
  // ------------------------------------------------------------
  task automatic init_regs();
    prog.push_back(addi(20, 0, DATA_BASE));
    for (int r = 1; r < 16; r++) prog.push_back(addi(r, 0, rand_imm()));
  endtask

  task automatic random_op(int off);
    int rd;
    int op;
    rd = rand_reg();
    op = int'($urandom % 7);
    case (op)
      0: prog.push_back(addi(rd, rand_reg(), rand_imm()));
      1: prog.push_back(r_type(3'b000, 7'h00, rd, rand_reg(), rand_reg()));  // add
      2: prog.push_back(r_type(3'b000, 7'h20, rd, rand_reg(), rand_reg()));  // sub
      3: prog.push_back(r_type(3'b111, 7'h00, rd, rand_reg(), rand_reg()));
      4: prog.push_back(r_type(3'b110, 7'h00, rd, rand_reg(), rand_reg()));
      5: prog.push_back(r_type(3'b100, 7'h00, rd, rand_reg(), rand_reg()));
      default: prog.push_back(r_type(3'b010, 7'h00, rd, rand_reg(), rand_reg()));
    endcase
    prog.push_back(s_type(rd, 20, off));
  endtask

  task automatic arith_program(int n);
    prog.delete();
    init_regs();
    for (int i = 0; i < n; i++) random_op(4 * i);
    prog.push_back(ECALL);
  endtask

  task automatic memory_program();
    int off;
    int dst;
    prog.delete();
    init_regs();
    for (int i = 0; i < 10; i++) begin
      off = 4 * int'($urandom % 16);
      dst = rand_reg();
      prog.push_back(s_type(rand_reg(), 20, off));
      prog.push_back(addi(21, 20, off + 8));  // computed address, read back below
      prog.push_back(i_type(OP_LOAD, 3'b010, dst, 21, -8));
      prog.push_back(s_type(dst, 20, 128 + off));
    end
    prog.push_back(ECALL);
  endtask

  task automatic branch_program();
    int v;
    v = rand_imm();
    prog.delete();
    prog.push_back(addi(20, 0, DATA_BASE));
    prog.push_back(addi(1, 0, v));
    prog.push_back(addi(2, 0, v));
    prog.push_back(addi(3, 0, v ^ 1));
    prog.push_back(addi(4, 0, rand_imm()));
    prog.push_back(addi(5, 0, rand_imm()));
    prog.push_back(b_type(3'b000, 1, 2, 8));  // beq taken
    prog.push_back(s_type(4, 20, 0));
    prog.push_back(s_type(5, 20, 4));
    prog.push_back(b_type(3'b000, 1, 3, 8));  // beq not taken
    prog.push_back(s_type(4, 20, 8));
    prog.push_back(b_type(3'b001, 1, 3, 8));  // bne taken
    prog.push_back(s_type(5, 20, 12));
    prog.push_back(b_type(3'b001, 1, 2, 8));  // bne not taken
    prog.push_back(s_type(5, 20, 16));
    prog.push_back(j_type(6, 12));            // jal over two stores
    prog.push_back(s_type(4, 20, 20));
    prog.push_back(s_type(4, 20, 24));
    prog.push_back(s_type(6, 20, 28));        // link value
    // countdown loop with a backward bne
    prog.push_back(addi(7, 0, 3));
    prog.push_back(s_type(7, 20, 32));
    prog.push_back(addi(7, 7, -1));
    prog.push_back(b_type(3'b001, 7, 0, -8));
    prog.push_back(ECALL);
  endtask

  task automatic lui_x0_program();
    prog.delete();
    prog.push_back(addi(20, 0, DATA_BASE));
    for (int i = 0; i < 4; i++) begin
      prog.push_back(u_type(8, 20'($urandom)));
      prog.push_back(s_type(8, 20, 16 * i));
      prog.push_back(u_type(0, 20'($urandom)));
      prog.push_back(s_type(0, 20, 16 * i + 4));
      prog.push_back(addi(0, 8, rand_imm()));
      prog.push_back(s_type(0, 20, 16 * i + 8));
      prog.push_back(r_type(3'b000, 7'h00, 0, 8, 8));
      prog.push_back(s_type(0, 20, 16 * i + 12));
    end
    prog.push_back(ECALL);
  endtask

  // stores after the stop word must never appear
  task automatic halt_program(instr_t stop_word);
    prog.delete();
    init_regs();
    for (int i = 0; i < 4; i++) random_op(4 * i);
    prog.push_back(stop_word);
    for (int i = 0; i < 4; i++) prog.push_back(s_type(rand_reg(), 20, 64 + 4 * i));
  endtask

  // ------------------------------------------------------------
  // reset, load through the load port, run until halted
  // ------------------------------------------------------------
  task automatic run_program(input string name, input bit stall);
    int cycles;
    test_name = name;
    exp_count = run_reference(prog);
    arst_n    = 1'b0;
    load_en   = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;
    // load has top priority, so the core waits in fetch meanwhile
    foreach (prog[i]) begin
      load_en   = 1'b1;
      load_addr = addr_t'(4 * i);
      load_data = prog[i];
      @(posedge clk);
      #1;
    end
    load_en = 1'b0;
    cycles  = 0;
    while (!halted && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      #1;
      load_en   = stall && ($urandom % 4 == 0);
      load_addr = FREE_BASE + addr_t'(4 * ($urandom % 256));
      load_data = $urandom;
      cycles++;
    end
    load_en = 1'b0;
    assert (halted) else begin
      run_errors++;
      $display("%s: core did not halt within %0d cycles", name, TIMEOUT_CYCLES);
    end
    repeat (DRAIN_CYCLES) begin
      @(posedge clk);
      #1;
      assert (halted) else begin
        run_errors++;
        $display("%s: halted dropped before reset", name);
      end
    end
    assert (store_idx == exp_addr.size()) else begin
      run_errors++;
      $display("error %s store count expected %0d actual %0d", name,
               exp_addr.size(), store_idx);
    end
    assert (instr_seen == exp_count) else begin
      run_errors++;
      $display("error %s instruction count expected %0d actual %0d", name,
               exp_count, instr_seen);
    end
  endtask

  // ------------------------------------------------------------
  // store trace comparison, sampled mid-cycle
  // ------------------------------------------------------------
  always @(negedge clk) begin
    if (!arst_n) begin
      store_idx  = 0;
      instr_seen = 0;
    end else begin
      if (dut.u_control_fsm.ir_write) instr_seen++;  // granted fetch
      if (mem_wr_valid) begin
        store_ok = (store_idx < exp_addr.size());
        assert (store_ok) else begin
          store_errors++;
          $display("%s: unexpected store to %h after the expected trace ended",
                   test_name, mem_wr_addr);
        end
        if (store_ok) begin
          assert (mem_wr_addr == exp_addr[store_idx]) else begin
            store_errors++;
            $display("error %s store %0d address expected %h actual %h", test_name,
                     store_idx, exp_addr[store_idx], mem_wr_addr);
          end
          assert (mem_wr_data == exp_data[store_idx]) else begin
            store_errors++;
            $display("error %s store %0d data expected %h actual %h", test_name,
                     store_idx, exp_data[store_idx], mem_wr_data);
          end
        end
        store_idx++;
      end
    end
  end

  initial begin
    void'($urandom(SEED));
    arith_program(30);
    run_program("arith", 1'b0);
    memory_program();
    run_program("load_store", 1'b0);
    branch_program();
    run_program("control_flow", 1'b0);
    lui_x0_program();
    run_program("lui_x0", 1'b0);
    halt_program(ECALL);
    run_program("halt_ecall", 1'b0);
    halt_program(ILLEGAL_OP);
    run_program("halt_undefined", 1'b0);
    arith_program(30);
    run_program("arbitration_arith", 1'b1);
    memory_program();
    run_program("arbitration_load_store", 1'b1);
    $display("store errors %0d, run errors %0d", store_errors, run_errors);
    if (store_errors == 0 && run_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+common
common/rv_pkg.sv
common/mem_bus_if.sv
control/control_fsm.sv
src/fetch_unit.sv
src/decode_regfile.sv
src/alu.sv
src/mem_arbiter.sv
src/unified_memory.sv
src/mc_core.sv
verification/tb_ref_pkg.sv
verification/tb_mc_core.sv

//--- Makefile
SIM = obj_dir/Vtb_mc_core

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): src.f $(shell cat src.f | grep -v '^+')
	verilator --binary --timing --assert -j 0 --top-module tb_mc_core -f src.f

# the simulation prints its own verdict, grep turns it into the exit status
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
